/* list.f */
+incdir+logic
logic/scratchpad_pkg.sv
logic/bank_hash.sv
logic/bank_port_if.sv
logic/hash_stage.sv
logic/bank_array.sv
logic/read_return.sv
logic/banked_scratchpad.sv
verification/scratchpad_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
  -f list.f --top-module scratchpad_tb -Mdir obj_dir

out=$(./obj_dir/Vscratchpad_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'STATUS: PASS'
then
  exit 0
fi
exit 1

/* verification/scratchpad_tests.txt */
# op addr data bank, with addr and data in hex and bank in decimal
# W write, R read and expect, I idle for data cycles, D drain, F fill all, C check all
W 00 1111 0
W 40 2222 1
W 80 3333 2
W c0 4444 0
W e0 6666 2
W f4 8888 1
W fc aaaa 0
W fe cccc 2
W ff dddd 0
W 7f 0e0e 1
W ef 1e1e 2
W f7 2e2e 1
I 00 0008 0
R 00 1111 0
R 40 2222 1
R 80 3333 2
R c0 4444 0
R e0 6666 2
R f4 8888 1
R fc aaaa 0
R fe cccc 2
R ff dddd 0
R 7f 0e0e 1
R ef 1e1e 2
R f7 2e2e 1
D 00 0000 0
W 5a 1234 1
R 5a 1234 1
W a5 beef 2
R a5 beef 2
W ff f00d 0
R ff f00d 0
F 00 0000 0
C 00 0000 0
D 00 0000 0

/* verification/scratchpad_tb.sv */
`timescale 1ns/100ps
`include "scratchpad_settings.svh"

module scratchpad_tb;

  import scratchpad_pkg::*;

  // Cycles to wait for the last outstanding read
  localparam int rsp_timeout_lp = 64;

  logic  clk_i;
  logic  rst_n_i;
  logic  req_valid_i;
  logic  req_write_i;
  addr_t req_addr_i;
  data_t req_wdata_i;
  logic  rsp_valid_o;
  bank_t rsp_bank_o;
  data_t rsp_rdata_o;

  // Expected contents, one word per address
  data_t model [2 ** `SP_ADDR_WIDTH];

  // Reads in flight, oldest at the front
  addr_t       exp_addr_q [$];
  bank_t       exp_bank_q [$];
  data_t       exp_data_q [$];
  int unsigned exp_cyc_q  [$];

  int unsigned cyc = 0;
  int unsigned lcg_state = 6981;

  // Counted by the response monitor
  int bank_errs = 0;
  int data_errs = 0;
  int late_errs = 0;
  int stray_errs = 0;
  // Counted by the stimulus flow
  int timeout_errs = 0;
  int file_errs = 0;

  banked_scratchpad i_banked_scratchpad
    (.clk_i      (clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.req_valid_i(req_valid_i)
    ,.req_write_i(req_write_i)
    ,.req_addr_i (req_addr_i)
    ,.req_wdata_i(req_wdata_i)
    ,.rsp_valid_o(rsp_valid_o)
    ,.rsp_bank_o (rsp_bank_o)
    ,.rsp_rdata_o(rsp_rdata_o)
    );

  // 20 ns clock
  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #10 clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
  end

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Skip leading 11 digits from the top
  // First other digit is the bank
  // All ones address lands in bank 0
  function automatic bank_t expected_bank_of(input addr_t addr);
    bank_t      bank;
    bit         found;
    logic [1:0] digit;
    bank  = '0;
    found = 1'b0;
    for (int d = `SP_ADDR_WIDTH / 2 - 1; d >= 0; d--)
    begin
      digit = addr[d*2 +: 2];
      if (!found && digit != 2'b11)
      begin
        bank  = bank_t'(digit);
        found = 1'b1;
      end
    end
    return bank;
  endfunction

  // Inputs change 2 ns after the edge
  task automatic drive_request(input logic valid, input logic write,
                               input addr_t addr, input data_t data);
    @(posedge clk_i);
    #2;
    req_valid_i = valid;
    req_write_i = write;
    req_addr_i  = addr;
    req_wdata_i = data;
  endtask

  task automatic issue_write(input addr_t addr, input data_t data);
    drive_request(1'b1, 1'b1, addr, data);
    model[addr] = data;
  endtask

  task automatic issue_read(input addr_t addr, input bank_t bank, input data_t data);
    drive_request(1'b1, 1'b0, addr, '0);
    exp_addr_q.push_back(addr);
    exp_bank_q.push_back(bank);
    exp_data_q.push_back(data);
    // Taken at the next edge, answered two edges after that
    exp_cyc_q.push_back(cyc + 3);
  endtask

  task automatic wait_for_responses(output bit timed_out);
    int waited;
    waited = 0;
    drive_request(1'b0, 1'b0, '0, '0);
    while (exp_bank_q.size() != 0 && waited < rsp_timeout_lp)
    begin
      @(posedge clk_i);
      waited++;
    end
    timed_out = (exp_bank_q.size() != 0);
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk_i)
  begin : check_response
    addr_t       exp_addr;
    bank_t       exp_bank;
    data_t       exp_data;
    int unsigned exp_cyc;
    if (rst_n_i && rsp_valid_o)
    begin
      assert (exp_bank_q.size() != 0)
      else
      begin
        $display("Response at %0t arrived with no read outstanding", $time);
        stray_errs++;
      end
      if (exp_bank_q.size() != 0)
      begin
        exp_addr = exp_addr_q.pop_front();
        exp_bank = exp_bank_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_cyc  = exp_cyc_q.pop_front();
        assert (rsp_bank_o == exp_bank)
        else
        begin
          $display("ERR %0t: addr %02h returned bank %0d, expected %0d",
                   $time, exp_addr, rsp_bank_o, exp_bank);
          bank_errs++;
        end
        assert (rsp_rdata_o == exp_data)
        else
        begin
          $display("ERR %0t: addr %02h returned data %04h, expected %04h",
                   $time, exp_addr, rsp_rdata_o, exp_data);
          data_errs++;
        end
        assert (cyc == exp_cyc)
        else
        begin
          $display("ERR %0t: addr %02h answered in cycle %0d, expected cycle %0d",
                   $time, exp_addr, cyc, exp_cyc);
          late_errs++;
        end
      end
    end
  end

  initial
  begin : stimulus
    int               fd;
    int               count;
    int               line_no;
    int               total;
    bit               stop;
    bit               timed_out;
    logic [8*128-1:0] line;
    logic [7:0]       op;
    addr_t            line_addr;
    data_t            line_data;
    bank_t            line_bank;

    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    stop        = 1'b0;
    timed_out   = 1'b0;
    line_no     = 0;

    // Reset held over two edges
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    fd = $fopen("verification/scratchpad_tests.txt", "r");
    assert (fd != 0)
    else
    begin
      $display("Could not open verification/scratchpad_tests.txt");
      file_errs++;
    end

    while (fd != 0 && !stop && !$feof(fd))
    begin
      line = '0;
      op   = '0;
      count = $fgets(line, fd);
      line_no++;
      if (count == 0)
        continue;
      count = $sscanf(line, "%s %h %h %d", op, line_addr, line_data, line_bank);
      // Blank and comment lines
      if (count <= 0 || op == "#")
        continue;
      assert (count == 4)
      else
      begin
        $display("Tests file line %0d is malformed", line_no);
        file_errs++;
      end
      if (count == 4)
      begin
        case (op)
          "W": issue_write(line_addr, line_data);
          "R": issue_read(line_addr, line_bank, line_data);
          "I": repeat (int'(line_data)) drive_request(1'b0, 1'b0, '0, '0);
          "D":
          begin
            wait_for_responses(timed_out);
            assert (!timed_out)
            else
            begin
              $display("Timed out waiting for %0d read responses", exp_bank_q.size());
              timeout_errs++;
              stop = 1'b1;
            end
          end
          // Every address gets fresh random data
          "F":
            for (int a = 0; a < 2 ** `SP_ADDR_WIDTH; a++)
              issue_write(addr_t'(a), data_t'(next_random() >> 16));
          "C":
            for (int a = 0; a < 2 ** `SP_ADDR_WIDTH; a++)
              issue_read(addr_t'(a), expected_bank_of(addr_t'(a)), model[addr_t'(a)]);
          default:
          begin
            $display("Tests file line %0d has an unknown operation", line_no);
            file_errs++;
          end
        endcase
      end
    end
    if (fd != 0)
      $fclose(fd);

    if (!stop)
    begin
      wait_for_responses(timed_out);
      assert (!timed_out)
      else
      begin
        $display("Timed out waiting for %0d read responses", exp_bank_q.size());
        timeout_errs++;
      end
    end
    // A few quiet cycles to catch stray responses
    repeat (4) drive_request(1'b0, 1'b0, '0, '0);

    total = bank_errs + data_errs + late_errs + stray_errs + timeout_errs + file_errs;
    $display("Errors: bank %0d, data %0d, timing %0d, stray %0d, timeout %0d, file %0d",
             bank_errs, data_errs, late_errs, stray_errs, timeout_errs, file_errs);
    if (total == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* logic/banked_scratchpad.sv */
`timescale 1ns/100ps
`include "scratchpad_settings.svh"

module banked_scratchpad
  (input  logic                  clk_i
  ,input  logic                  rst_n_i
  ,input  logic                  req_valid_i
  ,input  logic                  req_write_i
  ,input  scratchpad_pkg::addr_t req_addr_i
  ,input  scratchpad_pkg::data_t req_wdata_i
  ,output logic                  rsp_valid_o
  ,output scratchpad_pkg::bank_t rsp_bank_o
  ,output scratchpad_pkg::data_t rsp_rdata_o
  );

  import scratchpad_pkg::*;

  // Shared access bus from the hash stage to all banks
  bank_port_if bank_port ();

  // Read word of every bank, picked by the read return
  data_t bank_rdata [`SP_BANKS];

  // Address hash and access register
  hash_stage i_hash_stage
    (.clk_i      (clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.req_valid_i(req_valid_i)
    ,.req_write_i(req_write_i)
    ,.req_addr_i (req_addr_i)
    ,.req_wdata_i(req_wdata_i)
    ,.port_o     (bank_port)
    );

  // One memory per bank
  // Each decodes its own number from the shared bus
  for (genvar b = 0; b < `SP_BANKS; b++)
  begin : g_bank
    bank_array
      #(.bank_id_p(b)
       )
      i_bank_array
      (.clk_i  (clk_i)
      ,.port_i (bank_port)
      ,.rdata_o(bank_rdata[b])
      );
  end

  // Response select and alignment
  read_return i_read_return
    (.clk_i       (clk_i)
    ,.rst_n_i     (rst_n_i)
    ,.port_i      (bank_port)
    ,.bank_rdata_i(bank_rdata)
    ,.rsp_valid_o (rsp_valid_o)
    ,.rsp_bank_o  (rsp_bank_o)
    ,.rsp_rdata_o (rsp_rdata_o)
    );

endmodule

/* logic/read_return.sv */
`timescale 1ns/100ps
`include "scratchpad_settings.svh"

module read_return
  (input  logic                  clk_i
  ,input  logic                  rst_n_i
  ,bank_port_if.serve            port_i
  ,input  scratchpad_pkg::data_t bank_rdata_i [`SP_BANKS]
  ,output logic                  rsp_valid_o
  ,output scratchpad_pkg::bank_t rsp_bank_o
  ,output scratchpad_pkg::data_t rsp_rdata_o
  );

  import scratchpad_pkg::*;

  // Load presented to the banks this cycle
  logic  port_read;

  // Load that the banks are serving now
  logic  rd_valid_q;
  bank_t rd_bank_q;

  assign port_read = port_i.valid && !port_i.write;

  // Strobe follows the access through the bank read cycle
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      rd_valid_q  <= 1'b0;
      rsp_valid_o <= 1'b0;
    end
    else
    begin
      rd_valid_q  <= port_read;
      rsp_valid_o <= rd_valid_q;
    end
  end

  // Bank number rides next to the access
  // Its bank output is ready one cycle later
  always_ff @(posedge clk_i)
  begin
    if (port_read)
    begin
      rd_bank_q <= port_i.bank;
    end
    if (rd_valid_q)
    begin
      rsp_bank_o  <= rd_bank_q;
      rsp_rdata_o <= bank_rdata_i[rd_bank_q];
    end
  end

  // Two responses in a row need two loads in a row, two cycles earlier
  a_rsp_from_reads : assert property
    (@(posedge clk_i) disable iff (!rst_n_i)
     (rsp_valid_o && $past(rsp_valid_o)) |-> ($past(port_read, 2) && $past(port_read, 3)))
    else $error("back to back responses without two loads issued");

endmodule

/* logic/bank_array.sv */
`timescale 1ns/100ps
`include "scratchpad_settings.svh"

module bank_array
  #(parameter int bank_id_p = 0
  )
  (input  logic                  clk_i
  ,bank_port_if.serve            port_i
  ,output scratchpad_pkg::data_t rdata_o
  );

  import scratchpad_pkg::*;

  // Storage for this bank only
  data_t mem [`SP_BANK_DEPTH];

  // Access aimed at this bank
  logic hit;

  assign hit = port_i.valid && (port_i.bank == bank_t'(bank_id_p));

  // Single port, store on a write hit
  always_ff @(posedge clk_i)
  begin
    if (hit && port_i.write)
    begin
      mem[port_i.index] <= port_i.wdata;
    end
  end

  // Registered read
  // Output holds the last read word between loads
  always_ff @(posedge clk_i)
  begin
    if (hit && !port_i.write)
    begin
      rdata_o <= mem[port_i.index];
    end
  end

  // Any access this bank takes must fit its depth
  a_index_in_bank : assert property
    (@(posedge clk_i)
     hit |-> (int'(port_i.index) < `SP_BANK_DEPTH))
    else $error("bank %0d got index %0d past its depth",
                bank_id_p, port_i.index);

endmodule

/* logic/hash_stage.sv */
`timescale 1ns/100ps
`include "scratchpad_settings.svh"

module hash_stage
  (input  logic                  clk_i
  ,input  logic                  rst_n_i
  ,input  logic                  req_valid_i
  ,input  logic                  req_write_i
  ,input  scratchpad_pkg::addr_t req_addr_i
  ,input  scratchpad_pkg::data_t req_wdata_i
  ,bank_port_if.issue            port_o
  );

  import scratchpad_pkg::*;

  // Combinational hash result for the incoming address
  bank_t  hash_bank;
  index_t hash_index;

  bank_hash
    #(.banks_p(`SP_BANKS)
     ,.width_p(`SP_ADDR_WIDTH)
     )
    i_bank_hash
    (.addr_i (req_addr_i)
    ,.bank_o (hash_bank)
    ,.index_o(hash_index)
    );

  // Strobe into the banks, one cycle behind the request
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      port_o.valid <= 1'b0;
    end
    else
    begin
      port_o.valid <= req_valid_i;
    end
  end

  // Access fields only load with a request
  // Banks ignore them while valid is low
  always_ff @(posedge clk_i)
  begin
    if (req_valid_i)
    begin
      port_o.write <= req_write_i;
      port_o.bank  <= hash_bank;
      port_o.index <= hash_index;
      port_o.wdata <= req_wdata_i;
    end
  end

  // Hash must land inside the bank set and inside each bank
  a_access_in_range : assert property
    (@(posedge clk_i) disable iff (!rst_n_i)
     port_o.valid |-> (int'(port_o.bank) < `SP_BANKS) &&
                      (int'(port_o.index) < `SP_BANK_DEPTH))
    else $error("hash produced bank %0d index %0d out of range",
                port_o.bank, port_o.index);

endmodule

/* logic/bank_port_if.sv */
`timescale 1ns/100ps

interface bank_port_if;

  import scratchpad_pkg::*;

  // One cycle strobe, no handshake
  logic   valid;

  // High for a store, low for a load
  logic   write;

  // Target bank and word within it
  bank_t  bank;
  index_t index;

  // Store data, ignored on loads
  data_t  wdata;

  // Driven by the hash stage
  modport issue
    (output valid
    ,output write
    ,output bank
    ,output index
    ,output wdata
    );

  // Watched by every bank and by the read return
  modport serve
    (input valid
    ,input write
    ,input bank
    ,input index
    ,input wdata
    );

endinterface

/* logic/bank_hash.sv */
`timescale 1ns/100ps

module bank_hash
  #(parameter int banks_p = 1
   ,parameter int width_p = 1
   ,localparam int lg_banks_lp = (banks_p > 1) ? $clog2(banks_p) : 1
   ,localparam int index_width_lp = $clog2((2 ** width_p + banks_p - 1) / banks_p)
  )
  (input  logic [width_p-1:0]        addr_i
  ,output logic [lg_banks_lp-1:0]    bank_o
  ,output logic [index_width_lp-1:0] index_o
  );

  if (banks_p == 1)
  begin : g_one
    // Single bank takes the whole address as its index
    assign bank_o  = '0;
    assign index_o = addr_i;
  end
  else if (banks_p == 2)
  begin : g_two
    // Top bit picks the bank
    assign bank_o  = addr_i[width_p-1];
    assign index_o = addr_i[width_p-2:0];
  end
  else if ((banks_p & (banks_p - 1)) == 0)
  begin : g_pow2
    // Top bit becomes the low bank bit
    assign bank_o[0] = addr_i[width_p-1];

    // Remaining bits hash over half as many banks
    bank_hash
      #(.banks_p(banks_p >> 1)
       ,.width_p(width_p - 1)
       )
      i_bank_hash
      (.addr_i (addr_i[width_p-2:0])
      ,.bank_o (bank_o[lg_banks_lp-1:1])
      ,.index_o(index_o)
      );
  end
  else if ((banks_p & (banks_p + 1)) == 0)
  begin : g_mersenne
    if ((width_p % lg_banks_lp) != 0)
    begin : g_pad
      localparam int sub_index_width_lp =
        $clog2((2 ** (width_p + 1) + banks_p - 1) / banks_p);

      logic [sub_index_width_lp-1:0] sub_index;

      // Append a zero so the digits line up
      bank_hash
        #(.banks_p(banks_p)
         ,.width_p(width_p + 1)
         )
        i_bank_hash
        (.addr_i ({addr_i, 1'b0})
        ,.bank_o (bank_o)
        ,.index_o(sub_index)
        );

      // Low index bit only carries the padding
      assign index_o = sub_index[index_width_lp:1];
    end
    else
    begin : g_even
      localparam int digits_lp = width_p / lg_banks_lp;

      logic [digits_lp-1:0]                  all_ones;
      logic [digits_lp-1:0]                  skip;
      logic [digits_lp-1:0]                  border;
      logic [lg_banks_lp-1:0][digits_lp-1:0] digit_bits;
      logic [width_p-1:0]                    index_full;

      for (genvar d = 0; d < digits_lp; d++)
      begin : g_digit
        // Digit made of all ones is skipped over
        assign all_ones[d] = &addr_i[d*lg_banks_lp +: lg_banks_lp];

        // Transposed view, bit j of every digit side by side
        for (genvar j = 0; j < lg_banks_lp; j++)
        begin : g_bit
          assign digit_bits[j][d] = addr_i[d*lg_banks_lp + j];
        end

        // Skipped digit turns into one, border into zero, others pass
        assign index_full[d*lg_banks_lp +: lg_banks_lp] =
          skip[d]   ? lg_banks_lp'(1) :
          border[d] ? '0 :
                      addr_i[d*lg_banks_lp +: lg_banks_lp];
      end

      // Scan from the top digit down
      // Border is the first digit that breaks the run of all ones
      always_comb
      begin : scan
        logic run;
        run    = 1'b1;
        skip   = '0;
        border = '0;
        for (int d = digits_lp - 1; d >= 0; d--)
        begin
          border[d] = run & ~all_ones[d];
          run       = run & all_ones[d];
          skip[d]   = run;
        end
      end

      // Bank is the border digit, or zero when every digit is all ones
      for (genvar j = 0; j < lg_banks_lp; j++)
      begin : g_bank
        assign bank_o[j] = |(border & digit_bits[j]);
      end

      assign index_o = index_full[index_width_lp-1:0];
    end
  end
  else
  begin : g_bad
    $error("bank_hash cannot handle banks_p = %0d", banks_p);
  end

endmodule

/* logic/scratchpad_pkg.sv */
`include "scratchpad_settings.svh"

package scratchpad_pkg;

  // Bank number width
  // Kept at one bit even when there is only a single bank
  localparam int bank_width_lp = (`SP_BANKS > 1) ? $clog2(`SP_BANKS) : 1;

  // Index width inside one bank
  // Address space divided by bank count, rounded up
  localparam int index_width_lp =
    $clog2((2 ** `SP_ADDR_WIDTH + `SP_BANKS - 1) / `SP_BANKS);

  // Request address as seen at the top level
  typedef logic [`SP_ADDR_WIDTH-1:0] addr_t;

  // One stored data word
  typedef logic [`SP_DATA_WIDTH-1:0] data_t;

  // Bank number produced by the hash
  typedef logic [bank_width_lp-1:0] bank_t;

  // Word index inside the selected bank
  typedef logic [index_width_lp-1:0] index_t;

endpackage

/* logic/scratchpad_settings.svh */
`ifndef SCRATCHPAD_SETTINGS_SVH
`define SCRATCHPAD_SETTINGS_SVH

// Number of banks
// Must be one, a power of two, or two to the N minus one
`define SP_BANKS 3

// Request address width in bits
`define SP_ADDR_WIDTH 8

// Data word width in bits
`define SP_DATA_WIDTH 16

// Words per bank
// Largest hashed index plus one for 3 banks over 8 address bits
`define SP_BANK_DEPTH 86

`endif
